/* src/rob_pkg.sv */
package rob_pkg;

    // default configuration
    parameter int ROB_SIZE_DEF = 16;
    parameter int WIDTH_DEF = 2;
    parameter int WB_PORTS_DEF = 2;
    parameter int ROB_IDX_W = $clog2(ROB_SIZE_DEF);

    // architectural register number
    typedef logic [4:0] arch_reg_t;

    // physical register number
    typedef logic [5:0] phys_reg_t;

    // exception cause
    typedef logic [3:0] exc_code_t;

    // all ones marks an entry that completed without a fault
    parameter exc_code_t EXC_NONE = 4'hf;

endpackage

/* src/rob_index_ctrl.sv */
`timescale 1ns/10ps

module rob_index_ctrl #(
    parameter int ROB_SIZE = rob_pkg::ROB_SIZE_DEF,
    parameter int WIDTH = rob_pkg::WIDTH_DEF,
    localparam int IDX_W = $clog2(ROB_SIZE),
    localparam int CNT_W = $clog2(WIDTH) + 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] alloc_valid,
    input  logic [CNT_W-1:0] commit_num,
    input  logic             flush,
    output logic [IDX_W-1:0] head,
    output logic             head_dir,
    output logic [IDX_W-1:0] tail,
    output logic             tail_dir,
    output logic [IDX_W:0]   valid_count,
    output logic             alloc_ready,
    output logic             alloc_fire
);

    // pointers carry the direction bit on top
    logic [IDX_W:0] head_ext;
    logic [IDX_W:0] tail_ext;
    logic [IDX_W:0] head_ext_n;
    logic [IDX_W:0] free_count;
    logic [CNT_W-1:0] alloc_num;
    logic [CNT_W-1:0] add_num;
    logic init_done;

    always_comb begin
        alloc_num = '0;
        for (int i = 0; i < WIDTH; i++) begin
            alloc_num = alloc_num + CNT_W'(alloc_valid[i]);
        end
    end

    assign free_count = (IDX_W + 1)'(ROB_SIZE) - valid_count;

    // no new entries while the buffer is being flushed
    assign alloc_ready = init_done & (free_count >= (IDX_W + 1)'(WIDTH)) & ~flush;
    assign alloc_fire = alloc_ready & (|alloc_valid);
    assign add_num = alloc_fire ? alloc_num : '0;

    assign head_ext_n = head_ext + (IDX_W + 1)'(commit_num);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_ext <= '0;
            tail_ext <= '0;
            valid_count <= '0;
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
            head_ext <= head_ext_n;
            if (flush) begin
                // everything younger than the faulting entry is dropped
                tail_ext <= head_ext_n;
                valid_count <= '0;
            end else begin
                tail_ext <= tail_ext + (IDX_W + 1)'(add_num);
                valid_count <= valid_count + (IDX_W + 1)'(add_num)
                               - (IDX_W + 1)'(commit_num);
            end
        end
    end

    assign head = head_ext[IDX_W-1:0];
    assign head_dir = head_ext[IDX_W];
    assign tail = tail_ext[IDX_W-1:0];
    assign tail_dir = tail_ext[IDX_W];

endmodule

/* src/rob_status.sv */
`timescale 1ns/10ps

module rob_status #(
    parameter int ROB_SIZE = rob_pkg::ROB_SIZE_DEF,
    parameter int WIDTH = rob_pkg::WIDTH_DEF,
    parameter int WB_PORTS = rob_pkg::WB_PORTS_DEF,
    localparam int IDX_W = $clog2(ROB_SIZE)
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                alloc_fire,
    input  logic [WIDTH-1:0]                    alloc_valid,
    input  logic [IDX_W-1:0]                    tail,
    input  logic [WB_PORTS-1:0]                 wb_en,
    input  logic [WB_PORTS-1:0][IDX_W-1:0]      wb_idx,
    input  rob_pkg::exc_code_t [WB_PORTS-1:0]   wb_exc,
    input  logic [IDX_W-1:0]                    head,
    output logic [WIDTH-1:0]                    head_done,
    output rob_pkg::exc_code_t [WIDTH-1:0]      head_exc
);

    logic [ROB_SIZE-1:0] done;
    rob_pkg::exc_code_t exc_mem [ROB_SIZE];

    // written-back flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (alloc_fire && alloc_valid[i]) begin
                    done[tail + IDX_W'(i)] <= 1'b0;
                end
            end
            // writeback never targets a slot being allocated
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_en[p]) begin
                    done[wb_idx[p]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_en[p]) begin
                exc_mem[wb_idx[p]] <= wb_exc[p];
            end
        end
    end

    // read the oldest WIDTH slots
    for (genvar i = 0; i < WIDTH; i++) begin : g_head_rd
        logic [IDX_W-1:0] rd_idx;

        assign rd_idx = head + IDX_W'(i);
        assign head_done[i] = done[rd_idx];
        assign head_exc[i] = exc_mem[rd_idx];
    end

endmodule

/* src/rob_payload_ram.sv */
`timescale 1ns/10ps

module rob_payload_ram #(
    parameter int ROB_SIZE = rob_pkg::ROB_SIZE_DEF,
    parameter int WIDTH = rob_pkg::WIDTH_DEF,
    localparam int IDX_W = $clog2(ROB_SIZE)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc_fire,
    input  logic [WIDTH-1:0]                  alloc_valid,
    input  logic [IDX_W-1:0]                  tail,
    input  logic [WIDTH-1:0]                  alloc_we,
    input  rob_pkg::arch_reg_t [WIDTH-1:0]    alloc_vrd,
    input  rob_pkg::phys_reg_t [WIDTH-1:0]    alloc_prd,
    input  rob_pkg::phys_reg_t [WIDTH-1:0]    alloc_old_prd,
    input  logic [IDX_W-1:0]                  head,
    output logic [WIDTH-1:0]                  head_we,
    output rob_pkg::arch_reg_t [WIDTH-1:0]    head_vrd,
    output rob_pkg::phys_reg_t [WIDTH-1:0]    head_prd,
    output rob_pkg::phys_reg_t [WIDTH-1:0]    head_old_prd
);

    logic [ROB_SIZE-1:0] we_mem;
    rob_pkg::arch_reg_t vrd_mem [ROB_SIZE];
    rob_pkg::phys_reg_t prd_mem [ROB_SIZE];
    rob_pkg::phys_reg_t old_prd_mem [ROB_SIZE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            we_mem <= '0;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (alloc_fire && alloc_valid[i]) begin
                    we_mem[tail + IDX_W'(i)] <= alloc_we[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (alloc_fire && alloc_valid[i]) begin
                vrd_mem[tail + IDX_W'(i)] <= alloc_vrd[i];
                prd_mem[tail + IDX_W'(i)] <= alloc_prd[i];
                old_prd_mem[tail + IDX_W'(i)] <= alloc_old_prd[i];
            end
        end
    end

    // zero-latency read ports
    for (genvar i = 0; i < WIDTH; i++) begin : g_head_rd
        logic [IDX_W-1:0] rd_idx;

        assign rd_idx = head + IDX_W'(i);
        assign head_we[i] = we_mem[rd_idx];
        assign head_vrd[i] = vrd_mem[rd_idx];
        assign head_prd[i] = prd_mem[rd_idx];
        assign head_old_prd[i] = old_prd_mem[rd_idx];
    end

endmodule

/* src/rob_commit_select.sv */
`timescale 1ns/10ps

module rob_commit_select #(
    parameter int ROB_SIZE = rob_pkg::ROB_SIZE_DEF,
    parameter int WIDTH = rob_pkg::WIDTH_DEF,
    localparam int IDX_W = $clog2(ROB_SIZE),
    localparam int CNT_W = $clog2(WIDTH) + 1,
    localparam int LANE_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [IDX_W:0]                    valid_count,
    input  logic [IDX_W-1:0]                  head,
    input  logic                              head_dir,
    input  logic [WIDTH-1:0]                  head_done,
    input  rob_pkg::exc_code_t [WIDTH-1:0]    head_exc,
    input  logic [WIDTH-1:0]                  head_we,
    input  rob_pkg::arch_reg_t [WIDTH-1:0]    head_vrd,
    input  rob_pkg::phys_reg_t [WIDTH-1:0]    head_prd,
    input  rob_pkg::phys_reg_t [WIDTH-1:0]    head_old_prd,
    output logic [CNT_W-1:0]                  commit_num,
    output logic                              flush,
    output logic [WIDTH-1:0]                  commit_en,
    output logic [WIDTH-1:0]                  commit_we,
    output rob_pkg::arch_reg_t [WIDTH-1:0]    commit_vrd,
    output rob_pkg::phys_reg_t [WIDTH-1:0]    commit_prd,
    output rob_pkg::phys_reg_t [WIDTH-1:0]    commit_old_prd,
    output logic                              exc_valid,
    output logic [IDX_W:0]                    exc_idx,
    output rob_pkg::exc_code_t                exc_code
);

    logic [WIDTH-1:0] commit_mask;
    logic [WIDTH-1:0] lane_exc;
    logic [LANE_W-1:0] exc_lane;
    logic blocked;
    logic flush_q;

    for (genvar i = 0; i < WIDTH; i++) begin : g_exc
        assign lane_exc[i] = head_exc[i] != rob_pkg::EXC_NONE;
    end

    // in-order prefix of finished entries, cut after the first fault
    always_comb begin
        blocked = flush_q;
        commit_mask = '0;
        commit_num = '0;
        exc_lane = '0;
        flush = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (!blocked && (valid_count > (IDX_W + 1)'(i)) && head_done[i]) begin
                commit_mask[i] = 1'b1;
                commit_num = commit_num + 1'b1;
                if (lane_exc[i]) begin
                    flush = 1'b1;
                    exc_lane = LANE_W'(i);
                    blocked = 1'b1;
                end
            end else begin
                blocked = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_en <= '0;
            exc_valid <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            commit_en <= commit_mask;
            exc_valid <= flush;
            flush_q <= flush;
        end
    end

    always_ff @(posedge clk) begin
        // faulting entry keeps its mapping, no register write
        commit_we <= head_we & ~lane_exc;
        commit_vrd <= head_vrd;
        commit_prd <= head_prd;
        commit_old_prd <= head_old_prd;
        exc_idx <= {head_dir, head} + (IDX_W + 1)'(exc_lane);
        exc_code <= head_exc[exc_lane];
    end

endmodule

/* src/rob_top.sv */
`timescale 1ns/10ps

module rob_top #(
    parameter int ROB_SIZE = rob_pkg::ROB_SIZE_DEF,
    parameter int WIDTH = rob_pkg::WIDTH_DEF,
    parameter int WB_PORTS = rob_pkg::WB_PORTS_DEF,
    localparam int IDX_W = $clog2(ROB_SIZE),
    localparam int CNT_W = $clog2(WIDTH) + 1
) (
    input  logic                                clk,
    input  logic                                rst,
    // rename side
    input  logic [WIDTH-1:0]                    alloc_valid,
    input  logic [WIDTH-1:0]                    alloc_we,
    input  rob_pkg::arch_reg_t [WIDTH-1:0]      alloc_vrd,
    input  rob_pkg::phys_reg_t [WIDTH-1:0]      alloc_prd,
    input  rob_pkg::phys_reg_t [WIDTH-1:0]      alloc_old_prd,
    output logic                                alloc_ready,
    output logic [IDX_W:0]                      alloc_idx,
    // execution writeback
    input  logic [WB_PORTS-1:0]                 wb_en,
    input  logic [WB_PORTS-1:0][IDX_W-1:0]      wb_idx,
    input  rob_pkg::exc_code_t [WB_PORTS-1:0]   wb_exc,
    // retirement
    output logic [WIDTH-1:0]                    commit_en,
    output logic [WIDTH-1:0]                    commit_we,
    output rob_pkg::arch_reg_t [WIDTH-1:0]      commit_vrd,
    output rob_pkg::phys_reg_t [WIDTH-1:0]      commit_prd,
    output rob_pkg::phys_reg_t [WIDTH-1:0]      commit_old_prd,
    output logic                                exc_valid,
    output logic [IDX_W:0]                      exc_idx,
    output rob_pkg::exc_code_t                  exc_code
);

    logic [IDX_W-1:0] head;
    logic head_dir;
    logic [IDX_W-1:0] tail;
    logic tail_dir;
    logic [IDX_W:0] valid_count;
    logic alloc_fire;
    logic [CNT_W-1:0] commit_num;
    logic flush;
    logic [WIDTH-1:0] head_done;
    rob_pkg::exc_code_t [WIDTH-1:0] head_exc;
    logic [WIDTH-1:0] head_we;
    rob_pkg::arch_reg_t [WIDTH-1:0] head_vrd;
    rob_pkg::phys_reg_t [WIDTH-1:0] head_prd;
    rob_pkg::phys_reg_t [WIDTH-1:0] head_old_prd;

    assign alloc_idx = {tail_dir, tail};

    rob_index_ctrl #(
        .ROB_SIZE(ROB_SIZE),
        .WIDTH(WIDTH)
    ) u_index_ctrl (
        .clk(clk),
        .rst(rst),
        .alloc_valid(alloc_valid),
        .commit_num(commit_num),
        .flush(flush),
        .head(head),
        .head_dir(head_dir),
        .tail(tail),
        .tail_dir(tail_dir),
        .valid_count(valid_count),
        .alloc_ready(alloc_ready),
        .alloc_fire(alloc_fire)
    );

    rob_status #(
        .ROB_SIZE(ROB_SIZE),
        .WIDTH(WIDTH),
        .WB_PORTS(WB_PORTS)
    ) u_status (
        .clk(clk),
        .rst(rst),
        .alloc_fire(alloc_fire),
        .alloc_valid(alloc_valid),
        .tail(tail),
        .wb_en(wb_en),
        .wb_idx(wb_idx),
        .wb_exc(wb_exc),
        .head(head),
        .head_done(head_done),
        .head_exc(head_exc)
    );

    rob_payload_ram #(
        .ROB_SIZE(ROB_SIZE),
        .WIDTH(WIDTH)
    ) u_payload_ram (
        .clk(clk),
        .rst(rst),
        .alloc_fire(alloc_fire),
        .alloc_valid(alloc_valid),
        .tail(tail),
        .alloc_we(alloc_we),
        .alloc_vrd(alloc_vrd),
        .alloc_prd(alloc_prd),
        .alloc_old_prd(alloc_old_prd),
        .head(head),
        .head_we(head_we),
        .head_vrd(head_vrd),
        .head_prd(head_prd),
        .head_old_prd(head_old_prd)
    );

    rob_commit_select #(
        .ROB_SIZE(ROB_SIZE),
        .WIDTH(WIDTH)
    ) u_commit_select (
        .clk(clk),
        .rst(rst),
        .valid_count(valid_count),
        .head(head),
        .head_dir(head_dir),
        .head_done(head_done),
        .head_exc(head_exc),
        .head_we(head_we),
        .head_vrd(head_vrd),
        .head_prd(head_prd),
        .head_old_prd(head_old_prd),
        .commit_num(commit_num),
        .flush(flush),
        .commit_en(commit_en),
        .commit_we(commit_we),
        .commit_vrd(commit_vrd),
        .commit_prd(commit_prd),
        .commit_old_prd(commit_old_prd),
        .exc_valid(exc_valid),
        .exc_idx(exc_idx),
        .exc_code(exc_code)
    );

endmodule

/* test/rob_assert.sv */
`timescale 1ns/10ps

module rob_assert #(
    parameter int WIDTH = rob_pkg::WIDTH_DEF
) (
    input logic             clk,
    input logic             rst,
    input logic [WIDTH-1:0] commit_en,
    input logic             exc_valid
);

    int exc_fail = 0;
    int prefix_fail = 0;
    int quiet_fail = 0;
    logic [WIDTH:0] en_ext;

    assign en_ext = {1'b0, commit_en};

    // a fault retires together with its own entry
    exc_has_commit: assert property (@(posedge clk) disable iff (rst)
        exc_valid |-> commit_en != '0)
        else begin
            $error("exc_valid without any commit lane");
            exc_fail++;
        end

    // lanes retire from lane 0 upward with no gaps
    commit_prefix: assert property (@(posedge clk) disable iff (rst)
        ((en_ext + 1'b1) & en_ext) == '0)
        else begin
            $error("commit_en is not a contiguous prefix");
            prefix_fail++;
        end

    quiet_after_exc: assert property (@(posedge clk) disable iff (rst)
        exc_valid |=> commit_en == '0)
        else begin
            $error("commit in the cycle after an exception");
            quiet_fail++;
        end

endmodule

bind rob_commit_select rob_assert #(
    .WIDTH(WIDTH)
) u_rob_assert (
    .clk(clk),
    .rst(rst),
    .commit_en(commit_en),
    .exc_valid(exc_valid)
);

/* test/rob_tb.sv */
`timescale 1ns/10ps

module rob_tb;

    localparam int ROB_SIZE = 16;
    localparam int WIDTH = 2;
    localparam int WB_PORTS = 2;
    localparam int IDX_W = $clog2(ROB_SIZE);
    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_LIMIT = 400;

    typedef struct packed {
        logic [IDX_W:0] idx;
        logic we;
        rob_pkg::arch_reg_t vrd;
        rob_pkg::phys_reg_t prd;
        rob_pkg::phys_reg_t old_prd;
        logic done;
        rob_pkg::exc_code_t exc;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    logic [WIDTH-1:0] alloc_valid;
    logic [WIDTH-1:0] alloc_we;
    rob_pkg::arch_reg_t [WIDTH-1:0] alloc_vrd;
    rob_pkg::phys_reg_t [WIDTH-1:0] alloc_prd;
    rob_pkg::phys_reg_t [WIDTH-1:0] alloc_old_prd;
    logic alloc_ready;
    logic [IDX_W:0] alloc_idx;
    logic [WB_PORTS-1:0] wb_en;
    logic [WB_PORTS-1:0][IDX_W-1:0] wb_idx;
    rob_pkg::exc_code_t [WB_PORTS-1:0] wb_exc;
    logic [WIDTH-1:0] commit_en;
    logic [WIDTH-1:0] commit_we;
    rob_pkg::arch_reg_t [WIDTH-1:0] commit_vrd;
    rob_pkg::phys_reg_t [WIDTH-1:0] commit_prd;
    rob_pkg::phys_reg_t [WIDTH-1:0] commit_old_prd;
    logic exc_valid;
    logic [IDX_W:0] exc_idx;
    rob_pkg::exc_code_t exc_code;

    // reference model with the oldest entry at the front
    entry_t model_q[$];
    logic [IDX_W:0] tail_model;
    logic [IDX_W:0] last_exc_idx;
    integer seed;
    int errors;
    int tests_run;
    int tests_failed;
    int allocated;
    int committed;
    int discarded;
    int exc_seen;

    // traffic knobs
    bit alloc_enable;
    bit wb_enable;
    bit full_mode;
    bit offer_held;
    bit pend_alloc;
    bit force_exc;
    int exc_rate;
    logic [IDX_W:0] force_idx;
    logic [WB_PORTS-1:0] pend_wb_en;
    logic [IDX_W:0] pend_wb_idx [WB_PORTS];
    rob_pkg::exc_code_t pend_wb_exc [WB_PORTS];

    always #2 clk = ~clk;

    rob_top #(
        .ROB_SIZE(ROB_SIZE),
        .WIDTH(WIDTH),
        .WB_PORTS(WB_PORTS)
    ) u_rob_top (
        .clk(clk),
        .rst(rst),
        .alloc_valid(alloc_valid),
        .alloc_we(alloc_we),
        .alloc_vrd(alloc_vrd),
        .alloc_prd(alloc_prd),
        .alloc_old_prd(alloc_old_prd),
        .alloc_ready(alloc_ready),
        .alloc_idx(alloc_idx),
        .wb_en(wb_en),
        .wb_idx(wb_idx),
        .wb_exc(wb_exc),
        .commit_en(commit_en),
        .commit_we(commit_we),
        .commit_vrd(commit_vrd),
        .commit_prd(commit_prd),
        .commit_old_prd(commit_old_prd),
        .exc_valid(exc_valid),
        .exc_idx(exc_idx),
        .exc_code(exc_code)
    );

    function automatic int unsigned rnd(int unsigned n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic bit has_pending_exc();
        has_pending_exc = 1'b0;
        for (int k = 0; k < model_q.size(); k++) begin
            if (model_q[k].exc != rob_pkg::EXC_NONE) begin
                has_pending_exc = 1'b1;
            end
        end
    endfunction

    task automatic report_mismatch(string name, int unsigned exp, int unsigned act);
        $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("t=%0t %s", $time, msg);
        errors++;
    endtask

    // compare each retiring lane with the oldest model entry
    task automatic check_commit();
        entry_t e;
        bit exc_hit;
        exc_hit = 1'b0;
        if (exc_valid === 1'b1) begin
            exc_seen++;
            last_exc_idx = exc_idx;
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (commit_en[i] === 1'b1) begin
                committed++;
            end
            if (commit_en[i] && (exc_hit || model_q.size() == 0)) begin
                report_failure($sformatf("commit on lane %0d with no live entry left", i));
            end else if (commit_en[i]) begin
                e = model_q.pop_front();
                if (!e.done) report_failure("entry committed before its writeback");
                if (commit_vrd[i] !== e.vrd) report_mismatch("commit_vrd", e.vrd, commit_vrd[i]);
                if (commit_prd[i] !== e.prd) report_mismatch("commit_prd", e.prd, commit_prd[i]);
                if (commit_old_prd[i] !== e.old_prd) begin
                    report_mismatch("commit_old_prd", e.old_prd, commit_old_prd[i]);
                end
                if (e.exc != rob_pkg::EXC_NONE) begin
                    exc_hit = 1'b1;
                    if (commit_we[i] !== 1'b0) report_mismatch("commit_we", 0, commit_we[i]);
                    if (exc_valid !== 1'b1) report_mismatch("exc_valid", 1, exc_valid);
                    if (exc_idx !== e.idx) report_mismatch("exc_idx", e.idx, exc_idx);
                    if (exc_code !== e.exc) report_mismatch("exc_code", e.exc, exc_code);
                    // younger entries are dropped and the tail restarts after the fault
                    discarded += model_q.size();
                    model_q.delete();
                    tail_model = e.idx + 1'b1;
                end else if (commit_we[i] !== e.we) begin
                    report_mismatch("commit_we", e.we, commit_we[i]);
                end
            end
        end
        if (!exc_hit && exc_valid !== 1'b0) report_mismatch("exc_valid", 0, exc_valid);
    endtask

    task automatic apply_writebacks();
        entry_t e;
        for (int p = 0; p < WB_PORTS; p++) begin
            for (int k = 0; k < model_q.size(); k++) begin
                if (pend_wb_en[p] && model_q[k].idx == pend_wb_idx[p]) begin
                    e = model_q[k];
                    e.done = 1'b1;
                    e.exc = pend_wb_exc[p];
                    model_q[k] = e;
                end
            end
        end
    endtask

    task automatic apply_alloc();
        entry_t e;
        for (int i = 0; i < WIDTH; i++) begin
            if (pend_alloc && alloc_valid[i]) begin
                e.idx = tail_model;
                e.we = alloc_we[i];
                e.vrd = alloc_vrd[i];
                e.prd = alloc_prd[i];
                e.old_prd = alloc_old_prd[i];
                e.done = 1'b0;
                e.exc = rob_pkg::EXC_NONE;
                model_q.push_back(e);
                tail_model = tail_model + 1'b1;
                allocated++;
            end
        end
        pend_alloc = 1'b0;
    endtask

    task automatic drive_inputs();
        int cands[$];
        int n;
        int j;
        int k;
        if (!alloc_enable) begin
            alloc_valid = '0;
        end else if (!offer_held) begin
            n = full_mode ? int'(rnd(WIDTH)) + 1 : int'(rnd(WIDTH + 1));
            for (int i = 0; i < WIDTH; i++) begin
                alloc_valid[i] = i < n;
                alloc_we[i] = rnd(4) != 0;
                alloc_vrd[i] = rob_pkg::arch_reg_t'(rnd(32));
                alloc_prd[i] = rob_pkg::phys_reg_t'(rnd(64));
                alloc_old_prd[i] = rob_pkg::phys_reg_t'(rnd(64));
            end
        end
        // ready is a function of registered state only
        pend_alloc = alloc_ready && (alloc_valid != '0);
        offer_held = !alloc_ready && (alloc_valid != '0);
        wb_en = '0;
        for (k = 0; wb_enable && k < model_q.size(); k++) begin
            if (!model_q[k].done) cands.push_back(k);
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            if (cands.size() != 0 && rnd(3) != 0) begin
                j = int'(rnd(cands.size()));
                k = cands[j];
                cands.delete(j);
                wb_en[p] = 1'b1;
                wb_idx[p] = model_q[k].idx[IDX_W-1:0];
                if (force_exc && model_q[k].idx == force_idx) begin
                    wb_exc[p] = rob_pkg::exc_code_t'(3);
                end else if (exc_rate != 0 && rnd(exc_rate) == 0) begin
                    wb_exc[p] = rob_pkg::exc_code_t'(rnd(15));
                end else begin
                    wb_exc[p] = rob_pkg::EXC_NONE;
                end
                pend_wb_idx[p] = model_q[k].idx;
                pend_wb_exc[p] = wb_exc[p];
            end
        end
        pend_wb_en = wb_en;
    endtask

    task automatic step();
        bit exp_ready;
        @(negedge clk);
        check_commit();
        apply_writebacks();
        apply_alloc();
        if (alloc_idx !== tail_model) report_mismatch("alloc_idx", tail_model, alloc_idx);
        if (!has_pending_exc()) begin
            exp_ready = (ROB_SIZE - model_q.size()) >= WIDTH;
            if (alloc_ready !== exp_ready) report_mismatch("alloc_ready", exp_ready, alloc_ready);
        end
        drive_inputs();
    endtask

    task automatic drain(string what);
        int n;
        alloc_enable = 1'b0;
        wb_enable = 1'b1;
        n = 0;
        while ((model_q.size() != 0 || pend_alloc) && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (model_q.size() != 0 || pend_alloc) begin
            report_failure($sformatf("timeout: %s left %0d entries", what, model_q.size()));
        end
        repeat (2) step();
    endtask

    task automatic finish_test(string name, int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - err0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic verify_reset();
        int err0;
        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            if (commit_en !== '0) report_mismatch("commit_en", 0, commit_en);
            if (exc_valid !== 1'b0) report_mismatch("exc_valid", 0, exc_valid);
            if (alloc_ready !== 1'b0) report_mismatch("alloc_ready", 0, alloc_ready);
        end
        rst = 1'b0;
        @(negedge clk);
        if (alloc_ready !== 1'b1) report_mismatch("alloc_ready", 1, alloc_ready);
        if (alloc_idx !== '0) report_mismatch("alloc_idx", 0, alloc_idx);
        finish_test("reset", err0);
    endtask

    task automatic in_order_traffic();
        int err0;
        int a0;
        int c0;
        err0 = errors;
        a0 = allocated;
        c0 = committed;
        alloc_enable = 1'b1;
        wb_enable = 1'b1;
        repeat (400) step();
        drain("in-order traffic");
        if (committed - c0 != allocated - a0) begin
            report_mismatch("committed entries", allocated - a0, committed - c0);
        end
        finish_test("in_order", err0);
    endtask

    task automatic fill_to_full();
        int err0;
        int n;
        int low_run;
        err0 = errors;
        alloc_enable = 1'b1;
        wb_enable = 1'b0;
        full_mode = 1'b1;
        n = 0;
        low_run = 0;
        while (low_run < 4 && n < WAIT_LIMIT) begin
            step();
            n++;
            low_run = alloc_ready ? 0 : low_run + 1;
        end
        if (low_run < 4) report_failure("timeout: alloc_ready never stayed low with a full ROB");
        if (ROB_SIZE - model_q.size() >= WIDTH) begin
            report_failure($sformatf("ROB stalled with %0d free entries",
                                     ROB_SIZE - model_q.size()));
        end
        if (!offer_held) report_failure("source lanes were not held under back-pressure");
        full_mode = 1'b0;
        drain("full buffer");
        finish_test("full", err0);
    endtask

    task automatic exception_flush();
        int err0;
        int n;
        int total;
        int c0;
        int x0;
        logic [IDX_W:0] next_idx;
        err0 = errors;
        alloc_enable = 1'b1;
        wb_enable = 1'b0;
        full_mode = 1'b1;
        n = 0;
        while (model_q.size() < 6 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        alloc_enable = 1'b0;
        full_mode = 1'b0;
        repeat (2) step();
        if (model_q.size() < 6) begin
            report_failure("timeout: could not allocate six entries");
        end else begin
            total = model_q.size();
            force_idx = model_q[2].idx;
            next_idx = force_idx + 1'b1;
            force_exc = 1'b1;
            c0 = committed;
            x0 = exc_seen;
            drain("exception case");
            force_exc = 1'b0;
            if (exc_seen - x0 != 1) report_mismatch("exc_valid pulses", 1, exc_seen - x0);
            if (last_exc_idx !== force_idx) report_mismatch("exc_idx", force_idx, last_exc_idx);
            if (committed - c0 != 3) report_mismatch("commits up to fault", 3, committed - c0);
            if (alloc_idx !== next_idx) report_mismatch("alloc_idx", next_idx, alloc_idx);
        end
        finish_test("exception", err0);
    endtask

    task automatic mixed_traffic();
        int err0;
        int x0;
        err0 = errors;
        x0 = exc_seen;
        alloc_enable = 1'b1;
        wb_enable = 1'b1;
        exc_rate = 12;
        repeat (RANDOM_CYCLES) step();
        exc_rate = 0;
        drain("random traffic");
        if (exc_seen == x0) report_failure("random traffic raised no exception");
        if (committed + discarded != allocated) begin
            report_mismatch("commits plus discards", allocated, committed + discarded);
        end
        finish_test("random", err0);
    endtask

    initial begin
        seed = 32'h9f21;
        rst = 1'b1;
        alloc_valid = '0;
        alloc_we = '0;
        alloc_vrd = '0;
        alloc_prd = '0;
        alloc_old_prd = '0;
        wb_en = '0;
        wb_idx = '0;
        wb_exc = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        allocated = 0;
        committed = 0;
        discarded = 0;
        exc_seen = 0;
        alloc_enable = 1'b0;
        wb_enable = 1'b0;
        full_mode = 1'b0;
        offer_held = 1'b0;
        pend_alloc = 1'b0;
        force_exc = 1'b0;
        exc_rate = 0;
        force_idx = '0;
        tail_model = '0;
        last_exc_idx = '0;
        pend_wb_en = '0;
        verify_reset();
        in_order_traffic();
        fill_to_full();
        exception_flush();
        mixed_traffic();
        if (u_rob_top.u_commit_select.u_rob_assert.exc_fail
            + u_rob_top.u_commit_select.u_rob_assert.prefix_fail
            + u_rob_top.u_commit_select.u_rob_assert.quiet_fail != 0) begin
            report_failure("concurrent assertions fired in the commit logic");
        end
        $write("summary: %0d tests, %0d failed, %0d errors, ",
               tests_run, tests_failed, errors);
        $display("%0d allocated, %0d committed, %0d discarded",
                 allocated, committed, discarded);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rob.f */
src/rob_pkg.sv
src/rob_index_ctrl.sv
src/rob_status.sv
src/rob_payload_ram.sv
src/rob_commit_select.sv
src/rob_top.sv
test/rob_assert.sv
test/rob_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f rob.f -o rob_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/rob_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test completed successfully" "$SIM_LOG"; then
    exit 0
fi
exit 1
